// File: verilog/link_pkg.sv
// Hummingbird serial link definitions
// widths, counters, the frame struct handed to the cipher core,
// LED selection codes and the handshake FSM states
`default_nettype none

package link_pkg;

	localparam int BLOCK_W    = 128;
	localparam int KEY_W      = 128;
	localparam int IV_W       = 64;
	localparam int LOAD_BITS  = BLOCK_W + KEY_W + IV_W;
	localparam int SYNC_COUNT = 10;
	localparam int LED_W      = 16;

	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [KEY_W-1:0]   key_t;
	typedef logic [IV_W-1:0]    iv_t;
	typedef logic [LED_W-1:0]   led_word_t;
	typedef logic [8:0]         load_count_t;
	typedef logic [7:0]         send_count_t;

	// pt sits on top so an MSB-first shift fills pt, key, iv in order
	typedef struct packed {
		block_t pt;
		key_t   key;
		iv_t    iv;
	} cipher_in_t;

	//----------------------------------------------------------------------
	// LED selection codes, suffix is the 16-bit word index (0 = lsb word)
	//----------------------------------------------------------------------
	typedef enum logic [7:0] {
		SEL_PT7  = 8'b1000_0000, SEL_PT6  = 8'b1100_0000,
		SEL_PT5  = 8'b1110_0000, SEL_PT4  = 8'b1111_0000,
		SEL_PT3  = 8'b1111_1000, SEL_PT2  = 8'b1111_1100,
		SEL_PT1  = 8'b1111_1110, SEL_PT0  = 8'b1111_1111,
		SEL_KEY7 = 8'b0111_1111, SEL_KEY6 = 8'b0011_1111,
		SEL_KEY5 = 8'b0001_1111, SEL_KEY4 = 8'b0000_1111,
		SEL_KEY3 = 8'b0000_0111, SEL_KEY2 = 8'b0000_0011,
		SEL_KEY1 = 8'b0000_0001, SEL_KEY0 = 8'b0000_0000,
		SEL_IV3  = 8'b1010_0000, SEL_IV2  = 8'b1011_0000,
		SEL_IV1  = 8'b1011_1000, SEL_IV0  = 8'b1011_1100,
		SEL_CT7  = 8'b1001_0000, SEL_CT6  = 8'b1001_1000,
		SEL_CT5  = 8'b1001_1100, SEL_CT4  = 8'b1001_1110,
		SEL_CT3  = 8'b1001_1111, SEL_CT2  = 8'b1000_1000,
		SEL_CT1  = 8'b1000_1100, SEL_CT0  = 8'b1000_1110
	} led_sel_e;

	typedef enum logic [2:0] {
		SRC_NONE,
		SRC_PT,
		SRC_KEY,
		SRC_IV,
		SRC_CT
	} led_src_e;

	// decoded selection, source register and word index
	typedef struct packed {
		led_src_e   src;
		logic [2:0] word;
	} led_pick_t;

	typedef enum logic {
		LOAD_IDLE,
		LOAD_ACKED
	} loader_state_e;

	typedef enum logic {
		SEND_IDLE,
		SEND_REQUESTING
	} sender_state_e;

endpackage

`default_nettype wire

// File: verilog/level_filter.sv
// Level filter for one control line from the microcontroller
// a level counts as stable once held for SYNC_COUNT rising edges
`timescale 1ns/10ps
`default_nettype none

module level_filter (
	input  wire  clk,
	input  wire  rst,
	input  wire  line,
	output logic stable_high,
	output logic stable_low
);

	logic [3:0] high_cnt;
	logic [3:0] low_cnt;

	assign stable_high = (high_cnt == 4'(link_pkg::SYNC_COUNT));
	assign stable_low  = (low_cnt == 4'(link_pkg::SYNC_COUNT));

	// run length of the high level, saturates at the threshold
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			high_cnt <= '0;
		end
		else if (!line)
		begin
			high_cnt <= '0;
		end
		else if (!stable_high)
		begin
			high_cnt <= high_cnt + 4'd1;
		end
	end

	// same for the low level
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			low_cnt <= '0;
		end
		else if (line)
		begin
			low_cnt <= '0;
		end
		else if (!stable_low)
		begin
			low_cnt <= low_cnt + 4'd1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/bit_loader.sv
// Receive side of the link
// four-phase req/ack handshake, one bit per transfer, shifted MSB-first
// into the pt/key/iv frame that feeds the cipher core
`timescale 1ns/10ps
`default_nettype none

module bit_loader (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      req_high,
	input  wire                      req_low,
	input  wire                      data_in,
	output logic                     ack_out,
	output link_pkg::cipher_in_t     cipher_in
);

	link_pkg::loader_state_e         state;
	link_pkg::load_count_t           count;
	logic [link_pkg::LOAD_BITS-1:0]  frame;
	logic                            take_bit;

	// once the frame is full no request is answered again until reset
	assign take_bit = (state == link_pkg::LOAD_IDLE) && req_high
		&& (count < link_pkg::load_count_t'(link_pkg::LOAD_BITS));

	assign ack_out = (state == link_pkg::LOAD_ACKED);

	//----------------------------------------------------------------------
	// handshake FSM
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= link_pkg::LOAD_IDLE;
			count <= '0;
		end
		else
		begin
			case (state)
				link_pkg::LOAD_IDLE:
				begin
					if (take_bit)
					begin
						state <= link_pkg::LOAD_ACKED;
						count <= count + 9'd1;
					end
				end
				link_pkg::LOAD_ACKED:
				begin
					// wait for the partner to release req
					if (req_low)
					begin
						state <= link_pkg::LOAD_IDLE;
					end
				end
				default:
				begin
					state <= link_pkg::LOAD_IDLE;
				end
			endcase
		end
	end

	//----------------------------------------------------------------------
	// frame shift register and the copy presented to the core
	//----------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			frame <= '0;
		end
		else if (take_bit)
		begin
			frame <= {frame[link_pkg::LOAD_BITS-2:0], data_in};
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cipher_in <= '0;
		end
		else
		begin
			cipher_in <= frame;
		end
	end

endmodule

`default_nettype wire

// File: verilog/block_sender.sv
// Transmit side of the link
// returns the ciphertext LSB first, one bit per four-phase handshake,
// and stops after BLOCK_W transfers
`timescale 1ns/10ps
`default_nettype none

module block_sender (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    ct_valid_high,
	input  wire                    ack_high,
	input  wire                    ack_low,
	input  wire link_pkg::block_t  ct,
	output logic                   req_out,
	output logic                   ct_bit
);

	link_pkg::sender_state_e       state;
	link_pkg::send_count_t         count;
	logic                          start_bit;

	// a new transfer only starts once the previous ack has dropped
	assign start_bit = (state == link_pkg::SEND_IDLE) && ct_valid_high && ack_low
		&& (count < link_pkg::send_count_t'(link_pkg::BLOCK_W));

	assign req_out = (state == link_pkg::SEND_REQUESTING);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state  <= link_pkg::SEND_IDLE;
			count  <= '0;
			ct_bit <= 1'b0;
		end
		else
		begin
			case (state)
				link_pkg::SEND_IDLE:
				begin
					if (start_bit)
					begin
						state  <= link_pkg::SEND_REQUESTING;
						ct_bit <= ct[count[$clog2(link_pkg::BLOCK_W)-1:0]];
					end
				end
				link_pkg::SEND_REQUESTING:
				begin
					// partner has taken the bit
					if (ack_high)
					begin
						state <= link_pkg::SEND_IDLE;
						count <= count + 8'd1;
					end
				end
				default:
				begin
					state <= link_pkg::SEND_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/led_readout.sv
// LED readout
// decodes the 8-bit selection code into a source and word index and
// registers that 16-bit slice of pt, key, iv or ct for the board LEDs
`timescale 1ns/10ps
`default_nettype none

module led_readout (
	input  wire                        clk,
	input  wire                        rst,
	input  wire link_pkg::led_sel_e    led_sel,
	input  wire link_pkg::cipher_in_t  cipher_in,
	input  wire link_pkg::block_t      ct,
	output link_pkg::led_word_t        led_data
);

	link_pkg::led_pick_t   pick;
	link_pkg::led_word_t   slice;

	//----------------------------------------------------------------------
	// code decode
	//----------------------------------------------------------------------
	always_comb
	begin
		case (led_sel)
			link_pkg::SEL_PT7:  pick = '{link_pkg::SRC_PT, 3'd7};
			link_pkg::SEL_PT6:  pick = '{link_pkg::SRC_PT, 3'd6};
			link_pkg::SEL_PT5:  pick = '{link_pkg::SRC_PT, 3'd5};
			link_pkg::SEL_PT4:  pick = '{link_pkg::SRC_PT, 3'd4};
			link_pkg::SEL_PT3:  pick = '{link_pkg::SRC_PT, 3'd3};
			link_pkg::SEL_PT2:  pick = '{link_pkg::SRC_PT, 3'd2};
			link_pkg::SEL_PT1:  pick = '{link_pkg::SRC_PT, 3'd1};
			link_pkg::SEL_PT0:  pick = '{link_pkg::SRC_PT, 3'd0};
			link_pkg::SEL_KEY7: pick = '{link_pkg::SRC_KEY, 3'd7};
			link_pkg::SEL_KEY6: pick = '{link_pkg::SRC_KEY, 3'd6};
			link_pkg::SEL_KEY5: pick = '{link_pkg::SRC_KEY, 3'd5};
			link_pkg::SEL_KEY4: pick = '{link_pkg::SRC_KEY, 3'd4};
			link_pkg::SEL_KEY3: pick = '{link_pkg::SRC_KEY, 3'd3};
			link_pkg::SEL_KEY2: pick = '{link_pkg::SRC_KEY, 3'd2};
			link_pkg::SEL_KEY1: pick = '{link_pkg::SRC_KEY, 3'd1};
			link_pkg::SEL_KEY0: pick = '{link_pkg::SRC_KEY, 3'd0};
			link_pkg::SEL_IV3:  pick = '{link_pkg::SRC_IV, 3'd3};
			link_pkg::SEL_IV2:  pick = '{link_pkg::SRC_IV, 3'd2};
			link_pkg::SEL_IV1:  pick = '{link_pkg::SRC_IV, 3'd1};
			link_pkg::SEL_IV0:  pick = '{link_pkg::SRC_IV, 3'd0};
			link_pkg::SEL_CT7:  pick = '{link_pkg::SRC_CT, 3'd7};
			link_pkg::SEL_CT6:  pick = '{link_pkg::SRC_CT, 3'd6};
			link_pkg::SEL_CT5:  pick = '{link_pkg::SRC_CT, 3'd5};
			link_pkg::SEL_CT4:  pick = '{link_pkg::SRC_CT, 3'd4};
			link_pkg::SEL_CT3:  pick = '{link_pkg::SRC_CT, 3'd3};
			link_pkg::SEL_CT2:  pick = '{link_pkg::SRC_CT, 3'd2};
			link_pkg::SEL_CT1:  pick = '{link_pkg::SRC_CT, 3'd1};
			link_pkg::SEL_CT0:  pick = '{link_pkg::SRC_CT, 3'd0};
			default:            pick = '{link_pkg::SRC_NONE, 3'd0};
		endcase
	end

	// word n is bits [16n+15:16n] of the chosen source
	always_comb
	begin
		case (pick.src)
			link_pkg::SRC_PT:  slice = cipher_in.pt[pick.word*link_pkg::LED_W +: link_pkg::LED_W];
			link_pkg::SRC_KEY: slice = cipher_in.key[pick.word*link_pkg::LED_W +: link_pkg::LED_W];
			link_pkg::SRC_IV:  slice = cipher_in.iv[pick.word[1:0]*link_pkg::LED_W +: link_pkg::LED_W];
			link_pkg::SRC_CT:  slice = ct[pick.word*link_pkg::LED_W +: link_pkg::LED_W];
			default:           slice = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			led_data <= '0;
		end
		else
		begin
			led_data <= slice;
		end
	end

endmodule

`default_nettype wire

// File: verilog/link_top.sv
// Microcontroller link top level
// filters the incoming control lines and joins the bit loader,
// the ciphertext sender and the LED readout around the cipher core ports
`timescale 1ns/10ps
`default_nettype none

module link_top (
	input  wire                     clk,
	input  wire                     rst,
	// receive direction
	input  wire                     req_in,
	input  wire                     data_in,
	output logic                    ack_out,
	// transmit direction
	input  wire                     ct_valid,
	input  wire                     ack_in,
	output logic                    req_out,
	output logic                    ct_bit,
	// board LEDs
	input  wire  [7:0]              led_sel,
	output link_pkg::led_word_t     led_data,
	// cipher core
	output link_pkg::cipher_in_t    cipher_in,
	input  wire link_pkg::block_t   ct
);

	logic                  req_high;
	logic                  req_low;
	logic                  ack_high;
	logic                  ack_low;
	logic                  ct_valid_high;
	link_pkg::led_sel_e    led_code;

	assign led_code = link_pkg::led_sel_e'(led_sel);

	//----------------------------------------------------------------------
	// control line filters
	//----------------------------------------------------------------------
	level_filter req_filter_i (
		.clk         (clk),
		.rst         (rst),
		.line        (req_in),
		.stable_high (req_high),
		.stable_low  (req_low)
	);

	level_filter ack_filter_i (
		.clk         (clk),
		.rst         (rst),
		.line        (ack_in),
		.stable_high (ack_high),
		.stable_low  (ack_low)
	);

	// only the high level of ct_valid matters
	level_filter ct_valid_filter_i (
		.clk         (clk),
		.rst         (rst),
		.line        (ct_valid),
		.stable_high (ct_valid_high),
		.stable_low  ()
	);

	//----------------------------------------------------------------------
	// datapath blocks
	//----------------------------------------------------------------------
	bit_loader bit_loader_i (
		.clk       (clk),
		.rst       (rst),
		.req_high  (req_high),
		.req_low   (req_low),
		.data_in   (data_in),
		.ack_out   (ack_out),
		.cipher_in (cipher_in)
	);

	block_sender block_sender_i (
		.clk           (clk),
		.rst           (rst),
		.ct_valid_high (ct_valid_high),
		.ack_high      (ack_high),
		.ack_low       (ack_low),
		.ct            (ct),
		.req_out       (req_out),
		.ct_bit        (ct_bit)
	);

	led_readout led_readout_i (
		.clk       (clk),
		.rst       (rst),
		.led_sel   (led_code),
		.cipher_in (cipher_in),
		.ct        (ct),
		.led_data  (led_data)
	);

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
// Testbench clock and reset generator
// 4 ns clock, reset held over three rising edges at start and on request
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	input  wire  reset_req,
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	// release on a falling edge, away from the sampling point
	initial
	begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		forever
		begin
			@(posedge reset_req);
			rst = 1'b1;
			repeat (3) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verification/link_tb.sv
// Testbench for the microcontroller link
// plays the microcontroller on both handshakes and the cipher core on ct,
// runs a table of frames and a table of LED selection codes
`timescale 1ns/10ps
`default_nettype none

module link_tb;

	typedef struct packed {
		link_pkg::block_t pt;
		link_pkg::key_t   key;
		link_pkg::iv_t    iv;
		link_pkg::block_t ct;
	} data_row_t;

	typedef struct packed {
		logic [7:0]         code;
		link_pkg::led_src_e src;
		logic [2:0]         word;
	} led_row_t;

	logic                  clk;
	logic                  rst;
	logic                  reset_req;
	logic                  req_in;
	logic                  data_in;
	logic                  ack_out;
	logic                  ct_valid;
	logic                  ack_in;
	logic                  req_out;
	logic                  ct_bit;
	logic [7:0]            led_sel;
	link_pkg::led_word_t   led_data;
	link_pkg::cipher_in_t  cipher_in;
	link_pkg::block_t      ct;

	data_row_t             data_table [3];
	led_row_t              led_table [30];
	integer                seed;
	int                    wait_limit = 200;

	tb_clock tb_clock_i (
		.reset_req (reset_req),
		.clk       (clk),
		.rst       (rst)
	);

	link_top link_top_i (
		.clk       (clk),
		.rst       (rst),
		.req_in    (req_in),
		.data_in   (data_in),
		.ack_out   (ack_out),
		.ct_valid  (ct_valid),
		.ack_in    (ack_in),
		.req_out   (req_out),
		.ct_bit    (ct_bit),
		.led_sel   (led_sel),
		.led_data  (led_data),
		.cipher_in (cipher_in),
		.ct        (ct)
	);

	//----------------------------------------------------------------------
	// failure reporting and compares
	//----------------------------------------------------------------------
	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_cipher_in(input string name, input link_pkg::cipher_in_t expected,
		input link_pkg::cipher_in_t actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error: %s expected 0x%h, actual 0x%h",
				name, expected, actual));
	endtask

	task automatic check_led(input string name, input link_pkg::led_word_t expected,
		input link_pkg::led_word_t actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error: %s expected 0x%h, actual 0x%h",
				name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error: %s expected 0x%h, actual 0x%h",
				name, expected, actual));
	endtask

	//----------------------------------------------------------------------
	// cycle stepping and bounded waits
	//----------------------------------------------------------------------
	// inputs change and outputs are read 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic sync_to_reset_release();
		int cycles;
		cycles = 0;
		while (rst !== 1'b0)
		begin
			if (cycles == wait_limit)
				stop_on_failure("reset was never released");
			next_cycle();
			cycles++;
		end
	endtask

	task automatic wait_ack(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (ack_out !== level)
		begin
			if (cycles == wait_limit)
				stop_on_failure($sformatf("timed out waiting for %s", what));
			next_cycle();
			cycles++;
		end
	endtask

	task automatic wait_req_out(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (req_out !== level)
		begin
			if (cycles == wait_limit)
				stop_on_failure($sformatf("timed out waiting for %s", what));
			next_cycle();
			cycles++;
		end
	endtask

	task automatic hold_ack_low(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			next_cycle();
			check_bit("ack_out", 1'b0, ack_out);
		end
	endtask

	task automatic hold_req_low(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			next_cycle();
			check_bit("req_out", 1'b0, req_out);
		end
	endtask

	//----------------------------------------------------------------------
	// behaviors
	//----------------------------------------------------------------------
	// a loaded pt word is on the LEDs when reset arrives
	task automatic apply_reset();
		led_sel = 8'h80;
		next_cycle();
		reset_req = 1'b1;
		next_cycle();
		reset_req = 1'b0;
		confirm_reset_state();
		sync_to_reset_release();
	endtask

	task automatic confirm_reset_state();
		check_bit("ack_out", 1'b0, ack_out);
		check_bit("req_out", 1'b0, req_out);
		check_bit("ct_bit", 1'b0, ct_bit);
		check_led("led_data", '0, led_data);
		check_cipher_in("cipher_in", '0, cipher_in);
	endtask

	// a 6-cycle pulse never reaches the 10-cycle stability count
	task automatic short_req_ignored();
		req_in = 1'b1;
		for (int i = 0; i < 36; i++)
		begin
			if (i == 6)
				req_in = 1'b0;
			next_cycle();
			check_bit("ack_out", 1'b0, ack_out);
		end
	endtask

	// MSB first through pt then key then iv
	task automatic load_frame(input data_row_t row);
		logic b;
		for (int i = 0; i < link_pkg::LOAD_BITS; i++)
		begin
			if (i < link_pkg::BLOCK_W)
				b = row.pt[link_pkg::BLOCK_W-1-i];
			else if (i < link_pkg::BLOCK_W + link_pkg::KEY_W)
				b = row.key[link_pkg::BLOCK_W+link_pkg::KEY_W-1-i];
			else
				b = row.iv[link_pkg::LOAD_BITS-1-i];
			data_in = b;
			req_in = 1'b1;
			wait_ack(1'b1, "ack_out to rise");
			req_in = 1'b0;
			wait_ack(1'b0, "ack_out to fall");
		end
	endtask

	// slice n of a source is bits [16n+15:16n]
	task automatic led_table_sweep(input data_row_t row);
		link_pkg::led_word_t expected;
		int shift;
		for (int i = 0; i < 30; i++)
		begin
			led_sel = led_table[i].code;
			shift = link_pkg::LED_W * led_table[i].word;
			case (led_table[i].src)
				link_pkg::SRC_PT:  expected = link_pkg::led_word_t'(row.pt >> shift);
				link_pkg::SRC_KEY: expected = link_pkg::led_word_t'(row.key >> shift);
				link_pkg::SRC_IV:  expected = link_pkg::led_word_t'(row.iv >> shift);
				link_pkg::SRC_CT:  expected = link_pkg::led_word_t'(row.ct >> shift);
				default:           expected = '0;
			endcase
			next_cycle();
			next_cycle();
			check_led($sformatf("led_data (sel 0x%h)", led_table[i].code),
				expected, led_data);
		end
	endtask

	// LSB first with one bit per req_out/ack_in exchange
	task automatic send_block(input data_row_t row);
		ct_valid = 1'b1;
		for (int k = 0; k < link_pkg::BLOCK_W; k++)
		begin
			wait_req_out(1'b1, "req_out to rise");
			check_bit($sformatf("ct_bit[%0d]", k), row.ct[k], ct_bit);
			ack_in = 1'b1;
			wait_req_out(1'b0, "req_out to fall");
			ack_in = 1'b0;
		end
		hold_req_low(wait_limit);
		ct_valid = 1'b0;
	endtask

	task automatic fill_random_row(output data_row_t row);
		for (int w = 0; w < $bits(data_row_t) / 32; w++)
		begin
			row[w*32 +: 32] = $random(seed);
		end
	endtask

	//----------------------------------------------------------------------
	// stimulus tables
	//----------------------------------------------------------------------
	initial
	begin
		data_row_t            row;
		link_pkg::cipher_in_t expected_in;

		reset_req = 1'b0;
		req_in    = 1'b0;
		data_in   = 1'b0;
		ct_valid  = 1'b0;
		ack_in    = 1'b0;
		led_sel   = 8'h55;
		ct        = '0;
		seed      = 32'h62e9;

		data_table[0] = {128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff,
			128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0,
			64'hdead_beef_cafe_f00d,
			128'h8000_0000_0000_0001_1234_5678_9abc_def0};
		data_table[1] = {128'hffff_0000_ffff_0000_a5a5_5a5a_c3c3_3c3c,
			128'h0000_0000_0000_0000_0000_0000_0000_0001,
			64'h8000_0000_0000_0000,
			128'h5555_aaaa_0f0f_f0f0_ffff_ffff_0000_0000};
		fill_random_row(data_table[2]);

		// pt, key, iv and ct codes in word order 7 down to 0 and two unlisted ones
		led_table = '{
			{8'h80, link_pkg::SRC_PT, 3'd7},  {8'hc0, link_pkg::SRC_PT, 3'd6},
			{8'he0, link_pkg::SRC_PT, 3'd5},  {8'hf0, link_pkg::SRC_PT, 3'd4},
			{8'hf8, link_pkg::SRC_PT, 3'd3},  {8'hfc, link_pkg::SRC_PT, 3'd2},
			{8'hfe, link_pkg::SRC_PT, 3'd1},  {8'hff, link_pkg::SRC_PT, 3'd0},
			{8'h7f, link_pkg::SRC_KEY, 3'd7}, {8'h3f, link_pkg::SRC_KEY, 3'd6},
			{8'h1f, link_pkg::SRC_KEY, 3'd5}, {8'h0f, link_pkg::SRC_KEY, 3'd4},
			{8'h07, link_pkg::SRC_KEY, 3'd3}, {8'h03, link_pkg::SRC_KEY, 3'd2},
			{8'h01, link_pkg::SRC_KEY, 3'd1}, {8'h00, link_pkg::SRC_KEY, 3'd0},
			{8'ha0, link_pkg::SRC_IV, 3'd3},  {8'hb0, link_pkg::SRC_IV, 3'd2},
			{8'hb8, link_pkg::SRC_IV, 3'd1},  {8'hbc, link_pkg::SRC_IV, 3'd0},
			{8'h90, link_pkg::SRC_CT, 3'd7},  {8'h98, link_pkg::SRC_CT, 3'd6},
			{8'h9c, link_pkg::SRC_CT, 3'd5},  {8'h9e, link_pkg::SRC_CT, 3'd4},
			{8'h9f, link_pkg::SRC_CT, 3'd3},  {8'h88, link_pkg::SRC_CT, 3'd2},
			{8'h8c, link_pkg::SRC_CT, 3'd1},  {8'h8e, link_pkg::SRC_CT, 3'd0},
			{8'ha8, link_pkg::SRC_NONE, 3'd0}, {8'h55, link_pkg::SRC_NONE, 3'd0}
		};

		sync_to_reset_release();
		for (int r = 0; r < 3; r++)
		begin
			row = data_table[r];
			if (r > 0)
				apply_reset();
			confirm_reset_state();
			short_req_ignored();
			load_frame(row);
			// the 321st request must stay unanswered
			req_in = 1'b1;
			hold_ack_low(wait_limit);
			req_in = 1'b0;
			expected_in.pt  = row.pt;
			expected_in.key = row.key;
			expected_in.iv  = row.iv;
			check_cipher_in("cipher_in", expected_in, cipher_in);
			ct = row.ct;
			led_table_sweep(row);
			send_block(row);
			ct = '0;
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/link_pkg.sv
verilog/level_filter.sv
verilog/bit_loader.sv
verilog/block_sender.sv
verilog/led_readout.sv
verilog/link_top.sv
verification/tb_clock.sv
verification/link_tb.sv
